/* Bender.yml */
package:
  name: issue_front_end

sources:
  - files:
      - common/frontEndPkg.sv
      - common/instrChannelIf.sv
      - fetch/instrDecoder.sv
      - queue/instrQueue.sv
      - hazard/hazardIssue.sv
      - design/issueFrontEnd.sv
  - target: test
    files:
      - test/hazardIssue_properties.sv
      - test/issueFrontEndTb.sv

/* common/frontEndPkg.sv */
`default_nettype none

package frontEndPkg;

    // Word, register value and address share one width
    localparam int DataWidth = 16;
    localparam int RegAddrWidth = 3;

    // Queue entries, also the decoder's starting credit count
    localparam int QueueDepth = 4;

    // Older stages checked for hazards (ID, EX, MEM, WB)
    localparam int TrackDepth = 4;

    // Opcode field sits in the top bits of the word
    localparam int OpWidth = 5;

    // Low bits of the word hold the memory offset
    localparam int ImmWidth = 5;

    localparam int KindWidth = 2;

    // Queue pointer and occupancy sizing
    localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountWidth = $clog2(QueueDepth + 1);

    // Values are taken straight from instruction bits 15 to 11
    typedef enum logic [OpWidth-1:0] {
        OpNop     = 5'b00001,
        OpAddi    = 5'b01000,
        OpAdd     = 5'b11011,
        OpLoad    = 5'b10001,
        OpStore   = 5'b10000,
        OpJump    = 5'b00100,
        OpJumpReg = 5'b00101,
        OpBranch  = 5'b01100
    } opcodeT;

    // One slot leaves the issue stage every cycle
    typedef enum logic [KindWidth-1:0] {
        IssueIdle   = 2'd0,
        IssueInstr  = 2'd1,
        IssueBubble = 2'd2
    } issueKindT;

    // Decoded form of one instruction word
    typedef struct packed {
        opcodeT                  op;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        logic                    usesRs;
        logic                    usesRt;
        logic                    writesRd;
        logic                    memAccess;
        logic                    isControl;
        // Base plus sign-extended offset
        logic [DataWidth-1:0]    memAddr;
        logic [DataWidth-1:0]    raw;
    } decodedInstrT;

endpackage

`default_nettype wire

/* common/instrChannelIf.sv */
`timescale 1ns/1ps
`default_nettype none

// Credit channel between decoder and queue
interface instrChannelIf;
    import frontEndPkg::*;

    logic         pushValid;
    decodedInstrT pushEntry;
    // One pulse per freed queue slot
    logic         creditReturn;

    modport producer (
        output pushValid,
        output pushEntry,
        input  creditReturn
    );

    modport buffer (
        input  pushValid,
        input  pushEntry,
        output creditReturn
    );

endinterface

`default_nettype wire

/* design/issueFrontEnd.sv */
`timescale 1ns/1ps
`default_nettype none

module issueFrontEnd (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                inValid,
    input  logic [frontEndPkg::DataWidth-1:0]    inInstr,
    input  logic [frontEndPkg::DataWidth-1:0]    inBaseData,
    output logic                                inReady,
    output logic [frontEndPkg::KindWidth-1:0]    issueKind,
    output logic [frontEndPkg::OpWidth-1:0]      issueOp,
    output logic [frontEndPkg::RegAddrWidth-1:0] issueRd,
    output logic [frontEndPkg::DataWidth-1:0]    issueAddr,
    output logic [frontEndPkg::DataWidth-1:0]    issueWord
);
    import frontEndPkg::*;

    logic         popValid;
    logic         popReady;
    decodedInstrT popEntry;
    issueKindT    slotKind;
    opcodeT       slotOp;

    // Decoder to queue credit channel
    instrChannelIf chan ();

    instrDecoder decoder (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inInstr    (inInstr),
        .inBaseData (inBaseData),
        .inReady    (inReady),
        .chan       (chan.producer)
    );

    instrQueue queue (
        .clk      (clk),
        .rstN     (rstN),
        .chan     (chan.buffer),
        .popReady (popReady),
        .popValid (popValid),
        .popEntry (popEntry)
    );

    hazardIssue issue (
        .clk       (clk),
        .rstN      (rstN),
        .popValid  (popValid),
        .popEntry  (popEntry),
        .popReady  (popReady),
        .issueKind (slotKind),
        .issueOp   (slotOp),
        .issueRd   (issueRd),
        .issueAddr (issueAddr),
        .issueWord (issueWord)
    );

    // Enum outputs leave the top as plain vectors
    assign issueKind = slotKind;
    assign issueOp = slotOp;

endmodule

`default_nettype wire

/* fetch/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             inValid,
    input  logic [frontEndPkg::DataWidth-1:0] inInstr,
    input  logic [frontEndPkg::DataWidth-1:0] inBaseData,
    output logic                             inReady,
    instrChannelIf.producer                  chan
);
    import frontEndPkg::*;

    logic                  accept;
    logic                  wordValid;
    logic [DataWidth-1:0]  wordQ;
    logic [DataWidth-1:0]  baseQ;
    logic [CountWidth-1:0] credits;
    decodedInstrT          entry;

    // Push in flight already holds a credit
    assign inReady = credits > CountWidth'(chan.pushValid);
    assign accept = inValid && inReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wordValid <= 1'b0;
        end else begin
            wordValid <= accept;
        end
    end

    // Word and base value held for decode
    always_ff @(posedge clk) begin
        if (accept) begin
            wordQ <= inInstr;
            baseQ <= inBaseData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits <= CountWidth'(QueueDepth);
        end else begin
            case ({chan.pushValid, chan.creditReturn})
                2'b10:   credits <= credits - CountWidth'(1);
                2'b01:   credits <= credits + CountWidth'(1);
                default: credits <= credits;
            endcase
        end
    end

    always_comb begin : decode
        // Unknown codes become no-ops
        case (wordQ[DataWidth-1 -: OpWidth])
            OpAddi, OpAdd, OpLoad, OpStore, OpJump, OpJumpReg, OpBranch:
                entry.op = opcodeT'(wordQ[DataWidth-1 -: OpWidth]);
            default:
                entry.op = OpNop;
        endcase

        entry.rs = wordQ[10:8];
        entry.rt = wordQ[7:5];
        entry.rd = wordQ[4:2];
        entry.usesRs = 1'b0;
        entry.usesRt = 1'b0;
        entry.writesRd = 1'b0;
        entry.memAccess = 1'b0;
        entry.isControl = 1'b0;

        case (entry.op)
            OpAddi: begin
                entry.usesRs = 1'b1;
                entry.writesRd = 1'b1;
            end
            OpAdd: begin
                entry.usesRs = 1'b1;
                entry.usesRt = 1'b1;
                entry.writesRd = 1'b1;
            end
            OpLoad: begin
                entry.usesRs = 1'b1;
                entry.writesRd = 1'b1;
                entry.memAccess = 1'b1;
            end
            OpStore: begin
                entry.usesRs = 1'b1;
                entry.usesRt = 1'b1;
                entry.memAccess = 1'b1;
            end
            OpJump: entry.isControl = 1'b1;
            OpJumpReg, OpBranch: begin
                entry.usesRs = 1'b1;
                entry.isControl = 1'b1;
            end
            default: ;
        endcase

        // Base register plus sign-extended offset
        entry.memAddr = baseQ
            + {{(DataWidth - ImmWidth){wordQ[ImmWidth-1]}}, wordQ[ImmWidth-1:0]};
        entry.raw = wordQ;
    end

    assign chan.pushValid = wordValid;
    assign chan.pushEntry = entry;

endmodule

`default_nettype wire

/* hazard/hazardIssue.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardIssue (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                popValid,
    input  frontEndPkg::decodedInstrT           popEntry,
    output logic                                popReady,
    output frontEndPkg::issueKindT              issueKind,
    output frontEndPkg::opcodeT                 issueOp,
    output logic [frontEndPkg::RegAddrWidth-1:0] issueRd,
    output logic [frontEndPkg::DataWidth-1:0]    issueAddr,
    output logic [frontEndPkg::DataWidth-1:0]    issueWord
);
    import frontEndPkg::*;

    // Shadow of issued slots, index 0 is the youngest (ID)
    logic [TrackDepth-1:0]   trackValid;
    logic [TrackDepth-1:0]   trackWrites;
    logic [TrackDepth-1:0]   trackMem;
    logic [RegAddrWidth-1:0] trackRd [TrackDepth];
    logic [DataWidth-1:0]    trackAddr [TrackDepth];

    // Previous slot issued a jump or branch
    logic ctrlShadow;

    logic      regHazard;
    logic      memHazard;
    logic      headHazard;
    logic      issueNow;
    issueKindT slotKind;

    always_comb begin : hazardCheck
        regHazard = 1'b0;
        memHazard = 1'b0;
        for (int i = 0; i < TrackDepth; i++) begin
            // Read after write against any older writer
            if (trackValid[i] && trackWrites[i]) begin
                if (popEntry.usesRs && (popEntry.rs == trackRd[i])) begin
                    regHazard = 1'b1;
                end
                if (popEntry.usesRt && (popEntry.rt == trackRd[i])) begin
                    regHazard = 1'b1;
                end
            end
            // Same address still in flight
            if (popEntry.memAccess && trackValid[i] && trackMem[i]
                    && (popEntry.memAddr == trackAddr[i])) begin
                memHazard = 1'b1;
            end
        end
    end

    assign headHazard = popValid && (regHazard || memHazard);

    always_comb begin : slotSelect
        if (ctrlShadow || headHazard) begin
            slotKind = IssueBubble;
        end else if (!popValid) begin
            slotKind = IssueIdle;
        end else begin
            slotKind = IssueInstr;
        end
    end

    assign issueNow = slotKind == IssueInstr;
    assign popReady = issueNow;

    // Shadow advances every cycle, empty slots enter as invalid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            trackValid <= '0;
            trackWrites <= '0;
            trackMem <= '0;
            ctrlShadow <= 1'b0;
        end else begin
            trackValid <= {trackValid[TrackDepth-2:0], issueNow};
            trackWrites <= {trackWrites[TrackDepth-2:0], issueNow && popEntry.writesRd};
            trackMem <= {trackMem[TrackDepth-2:0], issueNow && popEntry.memAccess};
            ctrlShadow <= issueNow && popEntry.isControl;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = TrackDepth - 1; i > 0; i--) begin
            trackRd[i] <= trackRd[i-1];
            trackAddr[i] <= trackAddr[i-1];
        end
        trackRd[0] <= popEntry.rd;
        trackAddr[0] <= popEntry.memAddr;
    end

    // Registered slot outputs
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            issueKind <= IssueIdle;
            issueOp <= OpNop;
        end else begin
            issueKind <= slotKind;
            issueOp <= issueNow ? popEntry.op : OpNop;
        end
    end

    // Fields hold their last issued value between instructions
    always_ff @(posedge clk) begin
        if (issueNow) begin
            issueRd <= popEntry.rd;
            issueAddr <= popEntry.memAddr;
            issueWord <= popEntry.raw;
        end
    end

endmodule

`default_nettype wire

/* project.f */
common/frontEndPkg.sv
common/instrChannelIf.sv
fetch/instrDecoder.sv
queue/instrQueue.sv
hazard/hazardIssue.sv
design/issueFrontEnd.sv
test/hazardIssue_properties.sv
test/issueFrontEndTb.sv

/* queue/instrQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module instrQueue (
    input  logic                       clk,
    input  logic                       rstN,
    instrChannelIf.buffer              chan,
    input  logic                       popReady,
    output logic                       popValid,
    output frontEndPkg::decodedInstrT  popEntry
);
    import frontEndPkg::*;

    decodedInstrT          entries [QueueDepth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  push;
    logic                  pop;

    // Credits keep the producer from pushing into a full queue
    assign push = chan.pushValid;
    assign pop = popValid && popReady;

    assign popValid = count != '0;
    assign popEntry = entries[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= chan.pushEntry;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            chan.creditReturn <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + PtrWidth'(1);
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + PtrWidth'(1);
            end

            case ({push, pop})
                2'b10:   count <= count + CountWidth'(1);
                2'b01:   count <= count - CountWidth'(1);
                default: count <= count;
            endcase

            // Freed slot goes back to the decoder next cycle
            chan.creditReturn <= pop;
        end
    end

endmodule

`default_nettype wire

/* test/hazardIssue_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardIssueProperties (
    input logic                                 clk,
    input logic                                 rstN,
    input logic                                 popReady,
    input frontEndPkg::decodedInstrT            popEntry,
    input frontEndPkg::issueKindT               issueKind,
    input frontEndPkg::opcodeT                  issueOp,
    input logic [frontEndPkg::TrackDepth-1:0]   trackValid,
    input logic [frontEndPkg::TrackDepth-1:0]   trackWrites,
    input logic [frontEndPkg::TrackDepth-1:0]   trackMem,
    input logic [frontEndPkg::RegAddrWidth-1:0] trackRd [frontEndPkg::TrackDepth],
    input logic [frontEndPkg::DataWidth-1:0]    trackAddr [frontEndPkg::TrackDepth]
);
    import frontEndPkg::*;

    // Number of failed assertions
    int failures = 0;

    // Shadow slot after a jump or branch
    bubbleAfterControl: assert property (@(posedge clk) disable iff (!rstN)
        (issueKind == IssueInstr && issueOp inside {OpJump, OpJumpReg, OpBranch})
            |=> issueKind != IssueInstr)
        else begin
            failures++;
            $error("Instruction issued in the slot after a control transfer");
        end

    for (genvar i = 0; i < TrackDepth; i++) begin : stageCheck
        // Same address still in flight
        noPopOnHazard: assert property (@(posedge clk) disable iff (!rstN)
            (popReady && popEntry.memAccess && trackValid[i] && trackMem[i])
                |-> popEntry.memAddr != trackAddr[i])
            else begin
                failures++;
                $error("Pop while the head address matches shadow stage %0d", i);
            end

        noStaleSource: assert property (@(posedge clk) disable iff (!rstN)
            (popReady && trackValid[i] && trackWrites[i])
                |-> !(popEntry.usesRs && popEntry.rs == trackRd[i])
                    && !(popEntry.usesRt && popEntry.rt == trackRd[i]))
            else begin
                failures++;
                $error("Issued source matches the writer in shadow stage %0d", i);
            end
    end

endmodule

`default_nettype wire

/* test/issueFrontEndTb.sv */
`timescale 1ns/1ps
`default_nettype none

module issueFrontEndTb;
    import frontEndPkg::*;

    logic                    clk;
    logic                    rstN;
    logic                    inValid;
    logic [DataWidth-1:0]    inInstr;
    logic [DataWidth-1:0]    inBaseData;
    logic                    inReady;
    logic [KindWidth-1:0]    issueKind;
    logic [OpWidth-1:0]      issueOp;
    logic [RegAddrWidth-1:0] issueRd;
    logic [DataWidth-1:0]    issueAddr;
    logic [DataWidth-1:0]    issueWord;

    // Gap flag asks for a random idle gap before the row
    logic [DataWidth-1:0] rowWord [$];
    logic [DataWidth-1:0] rowBase [$];
    bit                   rowGap [$];
    int                   testLast [$];
    string                testName [$];

    // Reference model of queue contents and the four-stage shadow
    decodedInstrT mq [$];
    int           mqAvail [$];
    decodedInstrT shadow [TrackDepth];
    bit           shadowValid [TrackDepth] = '{default: 1'b0};
    bit           ctrlPending = 1'b0;

    int acceptCount = 0;
    int popCount = 0;
    int cycle = 0;
    int cycleLimit = 0;
    int checks = 0;
    int errors = 0;
    int testErrors = 0;
    int testIdx = 0;
    int rowIdx = 0;
    int gapLeft = 0;
    bit sawStall = 1'b0;

    issueFrontEnd uut (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inInstr    (inInstr),
        .inBaseData (inBaseData),
        .inReady    (inReady),
        .issueKind  (issueKind),
        .issueOp    (issueOp),
        .issueRd    (issueRd),
        .issueAddr  (issueAddr),
        .issueWord  (issueWord)
    );

    bind hazardIssue hazardIssueProperties props (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [DataWidth-1:0] makeWord(opcodeT op, int rs, int rt, int rd, int lo);
        return {op, 3'(rs), 3'(rt), 3'(rd), 2'(lo)};
    endfunction

    // Unknown codes act as no-ops
    function automatic decodedInstrT decodeWord(logic [DataWidth-1:0] word,
            logic [DataWidth-1:0] base);
        decodedInstrT d;
        d = '0;
        d.op = OpNop;
        if (word[15:11] inside {OpAddi, OpAdd, OpLoad, OpStore, OpJump, OpJumpReg, OpBranch}) begin
            d.op = opcodeT'(word[15:11]);
        end
        d.rs = word[10:8];
        d.rt = word[7:5];
        d.rd = word[4:2];
        d.usesRs = d.op inside {OpAddi, OpAdd, OpLoad, OpStore, OpJumpReg, OpBranch};
        d.usesRt = d.op inside {OpAdd, OpStore};
        d.writesRd = d.op inside {OpAddi, OpAdd, OpLoad};
        d.memAccess = d.op inside {OpLoad, OpStore};
        d.isControl = d.op inside {OpJump, OpJumpReg, OpBranch};
        d.memAddr = base + {{11{word[4]}}, word[4:0]};
        d.raw = word;
        return d;
    endfunction

    function automatic bit hazardFor(decodedInstrT d);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < TrackDepth; i++) begin
            if (shadowValid[i] && shadow[i].writesRd
                    && ((d.usesRs && d.rs == shadow[i].rd)
                        || (d.usesRt && d.rt == shadow[i].rd))) begin
                hit = 1'b1;
            end
            if (shadowValid[i] && d.memAccess && shadow[i].memAccess
                    && d.memAddr == shadow[i].memAddr) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic addRow(logic [DataWidth-1:0] word, logic [DataWidth-1:0] base, bit gap);
        rowWord.push_back(word);
        rowBase.push_back(base);
        rowGap.push_back(gap);
    endtask

    task automatic endTest(string name);
        testLast.push_back(rowWord.size() - 1);
        testName.push_back(name);
    endtask

    task automatic buildTable();
        addRow(makeWord(OpAddi, 0, 0, 1, 0), 16'h0000, 1'b1);
        addRow(makeWord(OpAdd, 0, 0, 2, 0), 16'h0000, 1'b0);
        addRow(makeWord(OpLoad, 0, 0, 3, 1), 16'h0100, 1'b1);
        addRow(makeWord(OpStore, 0, 0, 0, 2), 16'h0200, 1'b0);
        addRow(makeWord(OpAddi, 0, 0, 4, 0), 16'h0000, 1'b0);
        addRow(16'hF800, 16'h0000, 1'b1);
        endTest("independent");
        addRow(makeWord(OpAddi, 0, 0, 5, 0), 16'h0000, 1'b0);
        addRow(makeWord(OpAdd, 5, 0, 6, 0), 16'h0000, 1'b0);
        addRow(makeWord(OpAddi, 0, 0, 7, 0), 16'h0000, 1'b0);
        addRow(makeWord(OpNop, 0, 0, 0, 0), 16'h0000, 1'b0);
        addRow(makeWord(OpAdd, 0, 7, 1, 0), 16'h0000, 1'b0);
        addRow(makeWord(OpAddi, 6, 0, 2, 0), 16'h0000, 1'b0);
        endTest("register hazards");
        // Store and first load meet at 0x300, second pair at 0x40C
        addRow(makeWord(OpStore, 0, 0, 0, 0), 16'h0300, 1'b0);
        addRow(makeWord(OpLoad, 0, 0, 2, 0), 16'h02F8, 1'b0);
        addRow(makeWord(OpLoad, 0, 0, 3, 0), 16'h0400, 1'b0);
        addRow(makeWord(OpStore, 0, 0, 0, 0), 16'h040C, 1'b0);
        endTest("memory hazards");
        addRow(makeWord(OpJump, 0, 0, 0, 0), 16'h0000, 1'b1);
        addRow(makeWord(OpAddi, 0, 0, 1, 0), 16'h0000, 1'b0);
        addRow(makeWord(OpJumpReg, 0, 0, 0, 0), 16'h0000, 1'b1);
        addRow(makeWord(OpBranch, 0, 0, 0, 0), 16'h0000, 1'b0);
        addRow(makeWord(OpAddi, 0, 0, 3, 0), 16'h0000, 1'b0);
        endTest("control shadow");
        // Dependent chain stalls issue while words keep arriving
        addRow(makeWord(OpAddi, 0, 0, 1, 0), 16'h0000, 1'b0);
        for (int i = 1; i < 8; i++) begin
            addRow(makeWord(OpAdd, i, 0, (i % 7) + 1, 0), 16'h0000, 1'b0);
        end
        endTest("stalled burst");
    endtask

    task automatic noteError();
        errors++;
        testErrors++;
    endtask

    task automatic checkSlot(issueKindT got, issueKindT exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: slot kind %0d, expected %s", $time, got, exp.name());
            noteError();
        end
    endtask

    task automatic checkReady(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: inReady %b, expected %b", $time, got, exp);
            noteError();
        end
    endtask

    task automatic checkIssue(opcodeT gotOp, logic [RegAddrWidth-1:0] gotRd,
            logic [DataWidth-1:0] gotAddr, logic [DataWidth-1:0] gotWord, decodedInstrT exp);
        checks++;
        if (gotOp !== exp.op || gotRd !== exp.rd || gotAddr !== exp.memAddr
                || gotWord !== exp.raw) begin
            $display("Fail at %0t: issued word %h op %0d rd %0d addr %h, expected %h %s %0d %h",
                $time, gotWord, gotOp, gotRd, gotAddr, exp.raw, exp.op.name(), exp.rd,
                exp.memAddr);
            noteError();
        end
    endtask

    // Predicts the slot registered at the last rising edge
    task automatic modelStep();
        decodedInstrT head;
        issueKindT    expKind;
        bit           headReady;
        // Words accepted and not yet popped each hold a credit
        checkReady(inReady, (acceptCount - popCount) < QueueDepth);
        headReady = mq.size() > 0 && mqAvail[0] <= cycle;
        if (ctrlPending || (headReady && hazardFor(mq[0]))) begin
            expKind = IssueBubble;
        end else if (!headReady) begin
            expKind = IssueIdle;
        end else begin
            expKind = IssueInstr;
        end
        checkSlot(issueKindT'(issueKind), expKind);
        for (int i = TrackDepth - 1; i > 0; i--) begin
            shadow[i] = shadow[i-1];
            shadowValid[i] = shadowValid[i-1];
        end
        shadowValid[0] = 1'b0;
        ctrlPending = 1'b0;
        if (expKind == IssueInstr) begin
            head = mq.pop_front();
            void'(mqAvail.pop_front());
            checkIssue(opcodeT'(issueOp), issueRd, issueAddr, issueWord, head);
            shadow[0] = head;
            shadowValid[0] = 1'b1;
            ctrlPending = head.isControl;
            popCount++;
            if (testIdx < testLast.size() && popCount == testLast[testIdx] + 1) begin
                $display("Test %0d (%s) finished with %0d errors", testIdx + 1,
                    testName[testIdx], testErrors);
                testIdx++;
                testErrors = 0;
            end
        end
    endtask

    task automatic driveStep();
        if (gapLeft > 0) begin
            inValid = 1'b0;
            gapLeft--;
        end else if (rowIdx < rowWord.size()) begin
            inValid = 1'b1;
            inInstr = rowWord[rowIdx];
            inBaseData = rowBase[rowIdx];
        end else begin
            inValid = 1'b0;
        end
        if (inValid && !inReady) begin
            sawStall = 1'b1;
        end
        if (inValid && inReady) begin
            // Taken at the next rising edge
            mq.push_back(decodeWord(inInstr, inBaseData));
            mqAvail.push_back(cycle + 3);
            acceptCount++;
            rowIdx++;
            gapLeft = (rowIdx < rowWord.size() && rowGap[rowIdx]) ? int'($urandom % 3) : 0;
        end
    endtask

    initial begin
        void'($urandom(99));
        rstN = 1'b0;
        inValid = 1'b0;
        inInstr = '0;
        inBaseData = '0;
        buildTable();
        cycleLimit = rowWord.size() * 6 + 100;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        // Idle output and open input before any word
        checkSlot(issueKindT'(issueKind), IssueIdle);
        checkReady(inReady, 1'b1);
        while (popCount < rowWord.size() && cycle < cycleLimit) begin
            @(negedge clk);
            cycle++;
            modelStep();
            driveStep();
        end
        if (popCount < rowWord.size()) begin
            $display("Timeout after %0d cycles, %0d of %0d words issued", cycle, popCount,
                rowWord.size());
            $display("CHECKS FAILED");
        end else begin
            // Nothing more may leave once every word has issued
            repeat (QueueDepth + 3) begin
                @(negedge clk);
                cycle++;
                modelStep();
                driveStep();
            end
            if (!sawStall) begin
                $display("inReady never dropped while issue was stalled");
                errors++;
            end
            $display("Summary: %0d checks, %0d errors, %0d assertion failures", checks,
                errors, uut.issue.props.failures);
            if (errors == 0 && uut.issue.props.failures == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire
